// ==== Makefile ====
TOP = tb_fir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run, check $(LOG) for the pass line"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
rtl/fir_pkg.sv
rtl/axil_slave.sv
rtl/fir_regs.sv
rtl/coef_bank.sv
rtl/fir_mac.sv
rtl/fir_axil_top.sv
sim/fir_axil_assert.sv
sim/tb_fir.sv

// ==== rtl/axil_slave.sv ====
`timescale 1ns/100ps

module axil_slave import fir_pkg::*; (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// write address and data
	input  logic [AXI_ADDR_W-1:0]   S_AXI_AWADDR,
	input  logic                    S_AXI_AWVALID,
	output logic                    S_AXI_AWREADY,
	input  logic [AXI_DATA_W-1:0]   S_AXI_WDATA,
	input  logic [AXI_DATA_W/8-1:0] S_AXI_WSTRB,
	input  logic                    S_AXI_WVALID,
	output logic                    S_AXI_WREADY,
	// write response
	output logic [1:0]              S_AXI_BRESP,
	output logic                    S_AXI_BVALID,
	input  logic                    S_AXI_BREADY,
	// read address and data
	input  logic [AXI_ADDR_W-1:0]   S_AXI_ARADDR,
	input  logic                    S_AXI_ARVALID,
	output logic                    S_AXI_ARREADY,
	output logic [AXI_DATA_W-1:0]   S_AXI_RDATA,
	output logic [1:0]              S_AXI_RRESP,
	output logic                    S_AXI_RVALID,
	input  logic                    S_AXI_RREADY,
	// register side
	output logic                    wr_stb,
	output waddr_t                  wr_addr,
	output word_t                   wr_data,
	output waddr_t                  rd_addr,
	input  word_t                   rd_data
);

	logic awready_q; // aw and w ready move together
	logic bvalid_q;
	logic arready_q;
	logic rvalid_q;
	word_t rdata_q;
	logic rd_en;

	// write side
	// one ready pulse per write, held off while a b response is waiting
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			awready_q <= 1'b0;
		end else begin
			awready_q <= !awready_q && S_AXI_AWVALID && S_AXI_WVALID && !bvalid_q;
		end
	end

	assign wr_stb = awready_q && S_AXI_AWVALID && S_AXI_WVALID; // handshake cycle
	assign wr_addr = S_AXI_AWADDR[AXI_ADDR_W-1:2]; // valid still held by master
	assign wr_data = S_AXI_WDATA; // whole word, strobes not honoured

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			bvalid_q <= 1'b0;
		end else if (wr_stb) begin
			bvalid_q <= 1'b1; // one cycle after handshake
		end else if (S_AXI_BREADY && bvalid_q) begin
			bvalid_q <= 1'b0;
		end
	end

	// read side
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			arready_q <= 1'b0;
		end else begin
			arready_q <= !arready_q && S_AXI_ARVALID && !rvalid_q; // no read over a pending r
		end
	end

	assign rd_en = arready_q && S_AXI_ARVALID;
	assign rd_addr = S_AXI_ARADDR[AXI_ADDR_W-1:2];

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			rvalid_q <= 1'b0;
		end else if (rd_en) begin
			rvalid_q <= 1'b1;
		end else if (rvalid_q && S_AXI_RREADY) begin
			rvalid_q <= 1'b0;
		end
	end

	// capture decode result at accept
	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_en) begin
			rdata_q <= rd_data;
		end
	end

	assign S_AXI_AWREADY = awready_q;
	assign S_AXI_WREADY = awready_q;
	assign S_AXI_BVALID = bvalid_q;
	assign S_AXI_BRESP = 2'b00; // always okay
	assign S_AXI_ARREADY = arready_q;
	assign S_AXI_RVALID = rvalid_q;
	assign S_AXI_RDATA = rdata_q;
	assign S_AXI_RRESP = 2'b00;

endmodule

// ==== rtl/coef_bank.sv ====
`timescale 1ns/100ps

module coef_bank import fir_pkg::*; #(
	parameter int TAPS = TAPS_DEF
) (
	input  logic                    S_AXI_ACLK,
	// write port from register map
	input  logic                    cw_en,
	input  logic [$clog2(TAPS)-1:0] cw_idx,
	input  coef_t                   cw_data,
	// read port to mac
	input  logic [$clog2(TAPS)-1:0] cr_idx,
	output coef_t                   cr_data
);

	coef_t mem [TAPS]; // small enough for lut ram

	always_ff @(posedge S_AXI_ACLK) begin
		if (cw_en) begin
			mem[cw_idx] <= cw_data;
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge S_AXI_ACLK) begin
		cr_data <= mem[cr_idx];
	end

endmodule

// ==== rtl/fir_axil_top.sv ====
`timescale 1ns/100ps

module fir_axil_top import fir_pkg::*; #(
	parameter int TAPS = TAPS_DEF // 2 to 16
) (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	input  logic [AXI_ADDR_W-1:0]   S_AXI_AWADDR,
	input  logic                    S_AXI_AWVALID,
	output logic                    S_AXI_AWREADY,
	input  logic [AXI_DATA_W-1:0]   S_AXI_WDATA,
	input  logic [AXI_DATA_W/8-1:0] S_AXI_WSTRB,
	input  logic                    S_AXI_WVALID,
	output logic                    S_AXI_WREADY,
	output logic [1:0]              S_AXI_BRESP,
	output logic                    S_AXI_BVALID,
	input  logic                    S_AXI_BREADY,
	input  logic [AXI_ADDR_W-1:0]   S_AXI_ARADDR,
	input  logic                    S_AXI_ARVALID,
	output logic                    S_AXI_ARREADY,
	output logic [AXI_DATA_W-1:0]   S_AXI_RDATA,
	output logic [1:0]              S_AXI_RRESP,
	output logic                    S_AXI_RVALID,
	input  logic                    S_AXI_RREADY,
	// sample stream
	input  sample_t                 sample_in,
	input  logic                    sample_valid,
	output logic                    sample_ready,
	output sample_t                 out_data,
	output logic                    out_valid,
	output logic [7:0]              leds
);

	logic wr_stb;
	waddr_t wr_addr;
	word_t wr_data;
	waddr_t rd_addr;
	word_t rd_data;
	logic cw_en;
	logic [$clog2(TAPS)-1:0] cw_idx;
	coef_t cw_data;
	logic [$clog2(TAPS)-1:0] cr_idx;
	coef_t cr_data;
	logic filt_en;

	axil_slave u_axil (.*);

	fir_regs #(.TAPS(TAPS)) u_regs (.*); // map decode, control, coef routing

	coef_bank #(.TAPS(TAPS)) u_bank (.*);

	fir_mac #(.TAPS(TAPS)) u_mac (.*);

endmodule

// ==== rtl/fir_mac.sv ====
`timescale 1ns/100ps

module fir_mac import fir_pkg::*; #(
	parameter int TAPS = TAPS_DEF
) (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// sample stream
	input  sample_t                 sample_in,
	input  logic                    sample_valid,
	output logic                    sample_ready,
	output sample_t                 out_data,
	output logic                    out_valid,
	// control and coef bank
	input  logic                    filt_en,
	output logic [$clog2(TAPS)-1:0] cr_idx,
	input  coef_t                   cr_data
);

	localparam int IDX_W = $clog2(TAPS);

	typedef enum logic [1:0] {
		IDLE,
		RUN,   // stepping through coef reads
		DRAIN  // last product and output load
	} mac_state_t;

	mac_state_t state;
	sample_t dline [TAPS]; // dline[k] is x[n-k]
	logic accept;
	logic rd_vld;           // cr_data valid this cycle
	logic [IDX_W-1:0] k_d;  // tap index matching cr_data
	acc_t acc;
	acc_t prod;

	assign sample_ready = (state == IDLE); // one sample in flight at most
	assign accept = sample_valid && sample_ready;

	// delay line, shifts on every accept, bypass included
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int i = 0; i < TAPS; i++) begin
				dline[i] <= '0;
			end
		end else if (accept) begin
			dline[0] <= sample_in;
			for (int i = 1; i < TAPS; i++) begin
				dline[i] <= dline[i-1];
			end
		end
	end

	// sequencer
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state <= IDLE;
			cr_idx <= '0;
			rd_vld <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0; // single cycle pulse
			rd_vld <= (state == RUN); // bank read latency
			case (state)
				IDLE: begin
					if (accept) begin
						cr_idx <= '0;
						if (filt_en) begin
							state <= RUN;
						end else begin
							out_valid <= 1'b1; // bypass, next cycle
						end
					end
				end
				RUN: begin
					if (cr_idx == IDX_W'(TAPS - 1)) begin
						cr_idx <= '0;
						state <= DRAIN;
					end else begin
						cr_idx <= cr_idx + 1'b1;
					end
				end
				DRAIN: begin
					if (!rd_vld) begin // last product already in acc
						out_valid <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// datapath
	assign prod = acc_t'(cr_data) * acc_t'(dline[k_d]); // full precision, sign extended

	always_ff @(posedge S_AXI_ACLK) begin
		k_d <= cr_idx;
		if (accept) begin
			acc <= '0;
		end else if (rd_vld) begin
			acc <= acc + prod;
		end
	end

	// output register, q-shift then wrap to sample width
	always_ff @(posedge S_AXI_ACLK) begin
		if (accept && !filt_en) begin
			out_data <= sample_in;
		end else if (state == DRAIN && !rd_vld) begin
			out_data <= acc[COEF_FRAC +: SAMPLE_W];
		end
	end

endmodule

// ==== rtl/fir_pkg.sv ====
package fir_pkg;

	// sample and coefficient geometry
	localparam int SAMPLE_W = 14;  // adc/dac sample width
	localparam int COEF_W = 18;    // one dsp multiplier port
	localparam int COEF_FRAC = 17; // q1.17, also the final acc shift
	localparam int TAPS_DEF = 8;

	// bus geometry
	localparam int AXI_DATA_W = 32;
	localparam int AXI_ADDR_W = 16;
	localparam int WORD_ADDR_W = AXI_ADDR_W - 2; // byte address minus lsbs

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [SAMPLE_W+COEF_W+3:0] acc_t; // 4 guard bits, 16 taps max
	typedef logic [AXI_DATA_W-1:0] word_t;
	typedef logic [WORD_ADDR_W-1:0] waddr_t;

	// register map, word addresses
	localparam waddr_t REG_ID = 14'd0;
	localparam waddr_t REG_VER = 14'd1;
	localparam waddr_t REG_TAPS = 14'd2;
	localparam waddr_t REG_FRAC = 14'd3;
	localparam waddr_t REG_CTRL = 14'd4;
	localparam waddr_t COEF_BASE = 14'd64; // coef k at COEF_BASE + k, write only

	// identity words, first char in the top byte
	localparam word_t ID_WORD = "FIR ";
	localparam word_t VER_WORD = "1.00";

endpackage

// ==== rtl/fir_regs.sv ====
`timescale 1ns/100ps

module fir_regs import fir_pkg::*; #(
	parameter int TAPS = TAPS_DEF
) (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// from bus engine
	input  logic                    wr_stb,
	input  waddr_t                  wr_addr,
	input  word_t                   wr_data,
	input  waddr_t                  rd_addr,
	output word_t                   rd_data,
	// coefficient write port
	output logic                    cw_en,
	output logic [$clog2(TAPS)-1:0] cw_idx,
	output coef_t                   cw_data,
	// control outputs
	output logic                    filt_en,
	output logic [7:0]              leds
);

	localparam int IDX_W = $clog2(TAPS);
	localparam waddr_t COEF_END = COEF_BASE + waddr_t'(TAPS); // first address past the bank

	word_t ctrl_q; // bit 0 filter enable, 15:8 leds
	waddr_t coef_off;
	logic in_coef;

	// control register
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			ctrl_q <= '0;
		end else if (wr_stb && wr_addr == REG_CTRL) begin
			ctrl_q <= wr_data;
		end
	end

	assign filt_en = ctrl_q[0];
	assign leds = ctrl_q[15:8];

	// coefficient window decode
	assign in_coef = (wr_addr >= COEF_BASE) && (wr_addr < COEF_END);
	assign coef_off = wr_addr - COEF_BASE;

	assign cw_en = wr_stb && in_coef; // bank writes on the strobe edge
	assign cw_idx = coef_off[IDX_W-1:0];
	// sign from bit 31, magnitude from the low bits
	assign cw_data = {wr_data[AXI_DATA_W-1], wr_data[COEF_W-2:0]};

	// read mux
	always_comb begin
		case (rd_addr)
			REG_ID:   rd_data = ID_WORD;
			REG_VER:  rd_data = VER_WORD;
			REG_TAPS: rd_data = word_t'(TAPS);
			REG_FRAC: rd_data = word_t'(COEF_FRAC);
			REG_CTRL: rd_data = ctrl_q;
			default:  rd_data = '0; // coef window reads back zero too
		endcase
	end

endmodule

// ==== sim/fir_axil_assert.sv ====
`timescale 1ns/100ps

module fir_axil_assert (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	input logic sample_valid,
	input logic sample_ready,
	input logic out_valid,
	input logic filt_en
);

	logic busy; // filtered sample inside the mac

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			busy <= 1'b0;
		end else if (sample_valid && sample_ready && filt_en) begin
			busy <= 1'b1; // new accept wins over a finishing result
		end else if (out_valid) begin
			busy <= 1'b0;
		end
	end

	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID)
		else $error("rvalid dropped before rready");

	a_out_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		out_valid |=> !out_valid)
		else $error("out_valid high for two cycles");

	// result cycle itself reopens the input
	a_busy_ready: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		busy && !out_valid |-> !sample_ready)
		else $error("sample_ready high during a filtered sample");

endmodule

bind fir_axil_top fir_axil_assert u_assert (
	.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
	.S_AXI_BVALID(S_AXI_BVALID), .S_AXI_BREADY(S_AXI_BREADY),
	.S_AXI_RVALID(S_AXI_RVALID), .S_AXI_RREADY(S_AXI_RREADY),
	.sample_valid(sample_valid), .sample_ready(sample_ready),
	.out_valid(out_valid), .filt_en(filt_en)
);

// ==== sim/tb_fir.sv ====
`timescale 1ns/100ps

module tb_fir import fir_pkg::*; ();

	localparam int TAPS = 8;
	localparam int LIMIT = 200; // cycles allowed per wait

	logic S_AXI_ACLK, S_AXI_ARESETN;
	logic [AXI_ADDR_W-1:0] S_AXI_AWADDR, S_AXI_ARADDR;
	logic S_AXI_AWVALID, S_AXI_WVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_RREADY;
	logic S_AXI_AWREADY, S_AXI_WREADY, S_AXI_BVALID, S_AXI_ARREADY, S_AXI_RVALID;
	word_t S_AXI_WDATA, S_AXI_RDATA;
	logic [AXI_DATA_W/8-1:0] S_AXI_WSTRB;
	logic [1:0] S_AXI_BRESP, S_AXI_RRESP;
	sample_t sample_in, out_data;
	logic sample_valid, sample_ready, out_valid;
	logic [7:0] leds;

	integer seed = 32'hb4fa;
	int errors = 0;
	int tests = 0;
	int fails = 0;
	int ref_c [TAPS]; // model coefficients
	int ref_x [TAPS]; // model history, ref_x[k] is x[n-k]
	bit filt_on;      // model copy of control bit 0
	int imp_c [TAPS] = '{65536, 32768, -49152, 16384, 8192, 98304, -16384, 4096};

	fir_axil_top #(.TAPS(TAPS)) u_dut (.*);

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	task automatic report_timeout(input string what);
		$display("timeout at %0t: no %s within %0d cycles", $time, what, LIMIT);
		errors++;
	endtask

	task automatic report_mismatch(input string what, input longint got, input longint exp);
		$display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		errors++;
	endtask

	// stall keeps bready low for that many cycles after the handshake
	task automatic axil_write(input int waddr, input word_t data, input int stall);
		int n;
		S_AXI_AWADDR <= AXI_ADDR_W'(waddr * 4);
		S_AXI_WDATA <= data;
		S_AXI_AWVALID <= 1'b1;
		S_AXI_WVALID <= 1'b1;
		n = 0;
		do begin
			@(posedge S_AXI_ACLK);
			n++;
		end while (!S_AXI_AWREADY && n < LIMIT);
		if (!S_AXI_AWREADY) report_timeout("awready");
		else if (!S_AXI_WREADY) report_mismatch("wready at write handshake", S_AXI_WREADY, 1);
		S_AXI_AWVALID <= 1'b0;
		S_AXI_WVALID <= 1'b0;
		n = 0;
		do begin
			if (n == stall) S_AXI_BREADY <= 1'b1;
			@(posedge S_AXI_ACLK);
			n++;
			if (!S_AXI_BREADY && !S_AXI_BVALID) begin
				$display("error at %0t: bvalid went low while bready was held low", $time);
				errors++;
			end
		end while (!(S_AXI_BVALID && S_AXI_BREADY) && n < LIMIT);
		if (!(S_AXI_BVALID && S_AXI_BREADY)) report_timeout("write response");
		else if (S_AXI_BRESP !== 2'b00) report_mismatch("bresp", S_AXI_BRESP, 0);
		S_AXI_BREADY <= 1'b0;
	endtask

	task automatic axil_read(input int raddr, output word_t data);
		int n;
		S_AXI_ARADDR <= AXI_ADDR_W'(raddr * 4);
		S_AXI_ARVALID <= 1'b1;
		S_AXI_RREADY <= 1'b1;
		n = 0;
		do begin
			@(posedge S_AXI_ACLK);
			n++;
		end while (!S_AXI_ARREADY && n < LIMIT);
		if (!S_AXI_ARREADY) report_timeout("arready");
		S_AXI_ARVALID <= 1'b0;
		n = 0;
		do begin
			@(posedge S_AXI_ACLK);
			n++;
		end while (!S_AXI_RVALID && n < LIMIT);
		if (!S_AXI_RVALID) report_timeout("rvalid");
		else if (n != 1) report_mismatch("arready to rvalid cycles", n, 1);
		else if (S_AXI_RRESP !== 2'b00) report_mismatch("rresp", S_AXI_RRESP, 0);
		data = S_AXI_RDATA;
		S_AXI_RREADY <= 1'b0;
	endtask

	task automatic check_read(input int raddr, input word_t exp);
		word_t got;
		axil_read(raddr, got);
		if (got !== exp) report_mismatch($sformatf("read of word %0d", raddr), got, exp);
	endtask

	// sign in bit 31, low coefficient bits in place
	function automatic word_t coef_word(input int c);
		word_t w;
		w = '0;
		w[31] = (c < 0);
		w[COEF_W-2:0] = c[COEF_W-2:0];
		return w;
	endfunction

	// one sample through the dut, checked against the model
	task automatic push_sample(input sample_t x);
		int n;
		int lat;
		longint acc;
		sample_t exp;
		sample_in <= x;
		sample_valid <= 1'b1;
		n = 0;
		do begin
			@(posedge S_AXI_ACLK);
			n++;
		end while (!sample_ready && n < LIMIT);
		sample_valid <= 1'b0;
		if (!sample_ready) begin
			report_timeout("sample_ready");
			return;
		end
		for (int k = TAPS - 1; k > 0; k--) ref_x[k] = ref_x[k-1];
		ref_x[0] = x;
		acc = 0;
		for (int k = 0; k < TAPS; k++) acc += longint'(ref_c[k]) * ref_x[k];
		exp = filt_on ? sample_t'(acc >>> COEF_FRAC) : x; // cast wraps to 14 bits
		lat = filt_on ? TAPS + 3 : 1;
		n = 0;
		do begin
			@(posedge S_AXI_ACLK);
			n++;
		end while (!out_valid && n < LIMIT);
		if (!out_valid) report_timeout("out_valid");
		else if (n != lat) report_mismatch("accept to out_valid cycles", n, lat);
		else if (out_data !== exp) report_mismatch("out_data", out_data, exp);
		else if (!sample_ready) report_mismatch("sample_ready with out_valid", sample_ready, 1);
	endtask

	task automatic close_test(input string name, input int err_before);
		tests++;
		if (errors > err_before) fails++;
		$display("test %s finished with %0d errors", name, errors - err_before);
	endtask

	task automatic test_identity();
		int e;
		e = errors;
		check_read(0, "FIR ");
		check_read(1, "1.00");
		check_read(2, 32'd8);
		check_read(3, 32'd17);
		check_read(5, 32'd0);
		check_read(64, 32'd0); // coef window is write only
		close_test("identity", e);
	endtask

	task automatic test_control();
		int e;
		word_t w;
		e = errors;
		w = $random(seed) & 32'hffff_fffe; // keep the filter off
		axil_write(4, w, 4);
		check_read(4, w);
		if (leds !== w[15:8]) report_mismatch("leds", leds, w[15:8]);
		close_test("control", e);
	endtask

	task automatic test_bypass();
		int e;
		e = errors;
		filt_on = 1'b0;
		repeat (6) push_sample(sample_t'($random(seed)));
		close_test("bypass", e);
	endtask

	task automatic test_impulse();
		int e;
		e = errors;
		for (int k = 0; k < TAPS; k++) begin
			axil_write(64 + k, coef_word(imp_c[k]), 0);
			ref_c[k] = imp_c[k];
		end
		axil_write(4, 32'h0000_0101, 0);
		filt_on = 1'b1;
		push_sample(sample_t'(64)); // unit sample times 2**6
		repeat (TAPS - 1) push_sample('0);
		close_test("impulse", e);
	endtask

	task automatic test_stream();
		int e;
		e = errors;
		repeat (30) push_sample(sample_t'($random(seed) % 2048));
		close_test("stream", e);
	endtask

	initial begin
		S_AXI_ARESETN = 1'b0;
		S_AXI_AWADDR = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA = '0;
		S_AXI_WSTRB = '1;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b0;
		S_AXI_ARADDR = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY = 1'b0;
		sample_in = '0;
		sample_valid = 1'b0;
		repeat (2) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		@(posedge S_AXI_ACLK);
		test_identity();
		test_control();
		test_bypass();
		test_impulse();
		test_stream();
		$display("tests %0d, failed %0d, errors %0d", tests, fails, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
